//--- alu_iq_top.f
rtl/iq_pkg.sv
rtl/iq_alu.sv
rtl/iq_entry.sv
rtl/iq_ctrl.sv
rtl/iq_result_stage.sv
rtl/alu_iq_top.sv
tb/alu_iq_props.sv
tb/tb_alu_iq.sv

//--- rtl/alu_iq_top.sv
module alu_iq_top
    import iq_pkg::*;
#(
    parameter int IQ_SIZE   = 4,
    parameter int AGE_W     = 3,
    parameter int CDB_COUNT = 2
) (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 flush_i,
    input  logic                 disp_valid_i,
    input  dispatch_t            disp_i,
    output logic                 disp_ready_o,
    input  cdb_t [CDB_COUNT-1:0] cdb_i,
    output cdb_t                 res_o,
    output logic                 res_valid_o,
    input  logic                 res_ready_i
);

    logic                       disp_fire;
    logic [IQ_SIZE-1:0]         alloc;
    logic [IQ_SIZE-1:0]         issue_sel;
    logic [IQ_SIZE-1:0]         ent_busy;
    logic [IQ_SIZE-1:0]         ent_ready;
    logic                       issue;
    logic                       can_accept;
    cdb_t                       local_res;

    decode_info_t [IQ_SIZE-1:0] ent_di;
    word_t [IQ_SIZE-1:0]        ent_src1;
    word_t [IQ_SIZE-1:0]        ent_src2;

    decode_info_t               iss_di;
    word_t                      iss_a;
    word_t                      iss_b;
    word_t                      alu_res;

    assign disp_fire = disp_valid_i & disp_ready_o;

    iq_ctrl #(
        .IQ_SIZE (IQ_SIZE),
        .AGE_W   (AGE_W)
    ) u_ctrl (
        .clk            (clk),
        .reset_i        (reset_i),
        .flush_i        (flush_i),
        .disp_fire_i    (disp_fire),
        .entry_busy_i   (ent_busy),
        .entry_ready_i  (ent_ready),
        .can_accept_i   (can_accept),
        .alloc_o        (alloc),
        .issue_sel_o    (issue_sel),
        .issue_o        (issue),
        .disp_ready_o   (disp_ready_o)
    );

    for (genvar i = 0; i < IQ_SIZE; i++) begin : g_entry
        iq_entry #(
            .CDB_COUNT (CDB_COUNT)
        ) u_entry (
            .clk      (clk),
            .reset_i  (reset_i),
            .flush_i  (flush_i),
            .alloc_i  (alloc[i]),
            .issue_i  (issue_sel[i]),
            .disp_i   (disp_i),
            .cdb_i    (cdb_i),
            .local_i  (local_res),
            .busy_o   (ent_busy[i]),
            .ready_o  (ent_ready[i]),
            .di_o     (ent_di[i]),
            .src1_o   (ent_src1[i]),
            .src2_o   (ent_src2[i])
        );
    end

    // ----------------------------------------------------------------------
    // one-hot issue mux
    always_comb begin
        iss_di = '0;
        iss_a  = '0;
        iss_b  = '0;
        for (int i = 0; i < IQ_SIZE; i++) begin
            if (issue_sel[i]) begin
                iss_di = decode_info_t'(iss_di | ent_di[i]);
                iss_a  = iss_a | ent_src1[i];
                iss_b  = iss_b | ent_src2[i];
            end
        end
    end

    iq_alu u_alu (
        .op_i   (iss_di.op),
        .a_i    (iss_a),
        .b_i    (iss_b),
        .res_o  (alu_res)
    );

    iq_result_stage u_res (
        .clk           (clk),
        .reset_i       (reset_i),
        .flush_i       (flush_i),
        .issue_i       (issue),
        .dst_id_i      (iss_di.dst_id),
        .value_i       (alu_res),
        .res_ready_i   (res_ready_i),
        .res_o         (res_o),
        .res_valid_o   (res_valid_o),
        .can_accept_o  (can_accept),
        .local_o       (local_res)
    );

endmodule

//--- rtl/iq_alu.sv
module iq_alu
    import iq_pkg::*;
(
    input  alu_op_e op_i,
    input  word_t   a_i,
    input  word_t   b_i,
    output word_t   res_o
);

    logic [4:0] shamt;
    logic       lt;

    // only the low five bits count for shifts
    assign shamt = b_i[4:0];
    assign lt    = $signed(a_i) < $signed(b_i);

    always_comb begin
        case (op_i)
            ADD: begin
                res_o = a_i + b_i;
            end
            SUB: begin
                res_o = a_i - b_i;
            end
            AND: begin
                res_o = a_i & b_i;
            end
            OR: begin
                res_o = a_i | b_i;
            end
            XOR: begin
                res_o = a_i ^ b_i;
            end
            SLL: begin
                res_o = a_i << shamt;
            end
            SRL: begin
                // logical, zero fill
                res_o = a_i >> shamt;
            end
            SLT: begin
                res_o = word_t'(lt);
            end
            default: begin
                res_o = '0;
            end
        endcase
    end

endmodule

//--- rtl/iq_ctrl.sv
module iq_ctrl
    import iq_pkg::*;
#(
    parameter int IQ_SIZE = 4,
    parameter int AGE_W   = 3
) (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               flush_i,
    input  logic               disp_fire_i,
    input  logic [IQ_SIZE-1:0] entry_busy_i,
    input  logic [IQ_SIZE-1:0] entry_ready_i,
    input  logic               can_accept_i,
    output logic [IQ_SIZE-1:0] alloc_o,
    output logic [IQ_SIZE-1:0] issue_sel_o,
    output logic               issue_o,
    output logic               disp_ready_o
);

    localparam int CNT_W = $clog2(IQ_SIZE + 1);

    logic [IQ_SIZE-1:0][AGE_W-1:0] age_q;
    logic [CNT_W-1:0]              free_cnt_q;
    logic [CNT_W-1:0]              free_cnt_d;

    logic                          pick_found;
    int                            pick_idx;
    logic [AGE_W-1:0]              pick_age;

    // ----------------------------------------------------------------------
    // allocation: lowest free slot
    always_comb begin
        alloc_o = '0;
        for (int i = 0; i < IQ_SIZE; i++) begin
            if (!entry_busy_i[i] && alloc_o == '0) begin
                alloc_o[i] = disp_fire_i;
            end
        end
    end

    // ----------------------------------------------------------------------
    // select: oldest ready entry
    always_comb begin
        pick_found = 1'b0;
        pick_idx   = 0;
        pick_age   = '0;
        // strict compare keeps the lowest index on a tie
        for (int i = 0; i < IQ_SIZE; i++) begin
            if (entry_ready_i[i] && (!pick_found || age_q[i] > pick_age)) begin
                pick_found = 1'b1;
                pick_idx   = i;
                pick_age   = age_q[i];
            end
        end
    end

    assign issue_o = pick_found & can_accept_i;

    always_comb begin
        issue_sel_o = '0;
        for (int i = 0; i < IQ_SIZE; i++) begin
            issue_sel_o[i] = issue_o && (pick_idx == i);
        end
    end

    // saturating age per slot
    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            age_q <= '0;
        end else begin
            for (int i = 0; i < IQ_SIZE; i++) begin
                if (alloc_o[i]) begin
                    age_q[i] <= '0;
                end else if (entry_busy_i[i] && age_q[i] != '1) begin
                    age_q[i] <= age_q[i] + 1'b1;
                end
            end
        end
    end

    // ----------------------------------------------------------------------
    // free count and dispatch ready
    assign free_cnt_d = free_cnt_q - CNT_W'(disp_fire_i) + CNT_W'(issue_o);

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            free_cnt_q   <= CNT_W'(IQ_SIZE);
            disp_ready_o <= 1'b1;
        end else begin
            free_cnt_q   <= free_cnt_d;
            disp_ready_o <= (free_cnt_d != '0);
        end
    end

endmodule

//--- rtl/iq_entry.sv
module iq_entry
    import iq_pkg::*;
#(
    parameter int CDB_COUNT = 2
) (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 flush_i,
    input  logic                 alloc_i,
    input  logic                 issue_i,
    input  dispatch_t            disp_i,
    input  cdb_t [CDB_COUNT-1:0] cdb_i,
    input  cdb_t                 local_i,
    output logic                 busy_o,
    output logic                 ready_o,
    output decode_info_t         di_o,
    output word_t                src1_o,
    output word_t                src2_o
);

    logic               busy_q;
    logic               src1_rdy_q;
    logic               src2_rdy_q;
    decode_info_t       di_q;
    rob_id_t            src1_tag_q;
    word_t              src1_val_q;
    src2_u              src2_q;
    word_t              src2_val_q;

    cdb_t [CDB_COUNT:0] wk;
    rob_id_t            tag1;
    rob_id_t            tag2;
    logic               want1;
    logic               want2;
    logic               hit1;
    logic               hit2;
    word_t              val1;
    word_t              val2;
    logic               cap1;
    logic               cap2;

    // local result rides along as the top wakeup source
    assign wk = {local_i, cdb_i};

    // snoop the incoming tags too, so a broadcast during dispatch is kept
    assign tag1  = alloc_i ? disp_i.src1.tag : src1_tag_q;
    assign tag2  = alloc_i ? disp_i.src2.rs.tag : src2_q.rs.tag;
    assign want1 = alloc_i ? !disp_i.src1.valid : !src1_rdy_q;
    assign want2 = alloc_i ? !(disp_i.di.use_imm || disp_i.src2_valid) : !src2_rdy_q;

    always_comb begin
        hit1 = 1'b0;
        hit2 = 1'b0;
        val1 = '0;
        val2 = '0;
        for (int i = 0; i <= CDB_COUNT; i++) begin
            if (wk[i].valid && wk[i].rob_id == tag1) begin
                hit1 = 1'b1;
                val1 = wk[i].data;
            end
            if (wk[i].valid && wk[i].rob_id == tag2) begin
                hit2 = 1'b1;
                val2 = wk[i].data;
            end
        end
    end

    assign cap1 = want1 & hit1;
    assign cap2 = want2 & hit2;

    // ----------------------------------------------------------------------
    // control state
    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            busy_q     <= 1'b0;
            src1_rdy_q <= 1'b0;
            src2_rdy_q <= 1'b0;
        end else if (alloc_i) begin
            busy_q     <= 1'b1;
            src1_rdy_q <= !want1 || cap1;
            src2_rdy_q <= !want2 || cap2;
        end else begin
            if (issue_i) begin
                busy_q <= 1'b0;
            end
            if (cap1) begin
                src1_rdy_q <= 1'b1;
            end
            if (cap2) begin
                src2_rdy_q <= 1'b1;
            end
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (alloc_i) begin
            di_q       <= disp_i.di;
            src1_tag_q <= disp_i.src1.tag;
            src1_val_q <= cap1 ? val1 : disp_i.src1.value;
            src2_q     <= disp_i.src2;
            src2_val_q <= cap2 ? val2 : disp_i.src2_value;
        end else begin
            if (cap1) begin
                src1_val_q <= val1;
            end
            if (cap2) begin
                src2_val_q <= val2;
            end
        end
    end

    assign busy_o  = busy_q;
    assign ready_o = busy_q & src1_rdy_q & src2_rdy_q;
    assign di_o    = di_q;
    assign src1_o  = src1_val_q;
    assign src2_o  = di_q.use_imm ? src2_q.imm : src2_val_q;

endmodule

//--- rtl/iq_pkg.sv
package iq_pkg;

    // ----------------------------------------------------------------------
    // widths and base types
    localparam int XLEN  = 32;
    localparam int ROB_W = 4;

    typedef logic [XLEN-1:0]  word_t;
    typedef logic [ROB_W-1:0] rob_id_t;

    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        XOR = 3'd4,
        SLL = 3'd5,
        SRL = 3'd6,
        SLT = 3'd7
    } alu_op_e;

    // ----------------------------------------------------------------------
    // source 2 is a waiting tag or an immediate, never both
    typedef struct packed {
        logic [XLEN-ROB_W-1:0] pad;
        rob_id_t               tag;
    } src2_tag_t;

    typedef union packed {
        src2_tag_t rs;
        word_t     imm;
    } src2_u;

    typedef struct packed {
        logic    valid;
        rob_id_t tag;
        word_t   value;
    } operand_t;

    typedef struct packed {
        alu_op_e op;
        logic    use_imm;
        rob_id_t dst_id;
    } decode_info_t;

    typedef struct packed {
        decode_info_t di;
        operand_t     src1;
        logic         src2_valid;
        src2_u        src2;
        // only meaningful for a ready register operand
        word_t        src2_value;
    } dispatch_t;

    // one broadcast record, CDB or local result
    typedef struct packed {
        logic    valid;
        rob_id_t rob_id;
        word_t   data;
    } cdb_t;

endpackage

//--- rtl/iq_result_stage.sv
module iq_result_stage
    import iq_pkg::*;
(
    input  logic    clk,
    input  logic    reset_i,
    input  logic    flush_i,
    input  logic    issue_i,
    input  rob_id_t dst_id_i,
    input  word_t   value_i,
    input  logic    res_ready_i,
    output cdb_t    res_o,
    output logic    res_valid_o,
    output logic    can_accept_o,
    output cdb_t    local_o
);

    logic    valid_q;
    rob_id_t dst_q;
    word_t   data_q;
    logic    xfer;

    assign xfer = valid_q & res_ready_i;

    // empty, or draining this cycle
    assign can_accept_o = !valid_q || res_ready_i;

    // ----------------------------------------------------------------------
    // valid flag
    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            valid_q <= 1'b0;
        end else if (issue_i) begin
            valid_q <= 1'b1;
        end else if (xfer) begin
            valid_q <= 1'b0;
        end
    end

    // record, held while the consumer stalls
    always_ff @(posedge clk) begin
        if (issue_i) begin
            dst_q  <= dst_id_i;
            data_q <= value_i;
        end
    end

    // ----------------------------------------------------------------------
    // outputs
    always_comb begin
        res_o.valid  = valid_q;
        res_o.rob_id = dst_q;
        res_o.data   = data_q;
    end

    assign res_valid_o = valid_q;

    // wakeup only on an actual transfer
    always_comb begin
        local_o = '0;
        if (xfer) begin
            local_o = res_o;
        end
    end

endmodule

//--- run.sh
#!/usr/bin/env bash
# build and run the ALU issue queue testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert \
    --top-module tb_alu_iq \
    -f alu_iq_top.f \
    -Mdir obj_dir \
    -o sim_alu_iq

# keep running after an assertion error so the testbench can report its counts
./obj_dir/sim_alu_iq +verilator+error+limit+1000 | tee sim.log

if grep -q "^TB PASSED$" sim.log; then
    echo "run.sh: simulation passed"
    exit 0
fi
echo "run.sh: simulation failed, see sim.log"
exit 1

//--- tb/alu_iq_props.sv
module alu_iq_props
    import iq_pkg::*;
#(
    parameter int IQ_SIZE = 4
) (
    input logic               clk,
    input logic               reset_i,
    input logic               flush_i,
    input logic               disp_ready_i,
    input logic [IQ_SIZE-1:0] alloc_i,
    input logic [IQ_SIZE-1:0] busy_i,
    input cdb_t               res_i,
    input logic               res_valid_i,
    input logic               res_ready_i
);

    int unsigned fail_cnt = 0;

    // ----------------------------------------------------------------------
    // dispatch side
    full_blocks_alloc: assert property (@(posedge clk) disable iff (reset_i)
        !disp_ready_i |-> (alloc_i == '0) && (&busy_i))
        else begin
            fail_cnt++;
            $error("a slot was allocated while the queue reported full");
        end

    // ----------------------------------------------------------------------
    // result side
    stall_holds: assert property (@(posedge clk) disable iff (reset_i)
        res_valid_i && !res_ready_i && !flush_i |=> res_valid_i && $stable(res_i))
        else begin
            fail_cnt++;
            $error("held result changed or vanished under back-pressure");
        end

    // state one cycle after flush and after reset
    flush_clears: assert property (@(posedge clk) disable iff (reset_i)
        flush_i |=> !res_valid_i && disp_ready_i)
        else begin
            fail_cnt++;
            $error("result valid or dispatch blocked one cycle after flush");
        end

    reset_clears: assert property (@(posedge clk)
        reset_i |=> !res_valid_i && disp_ready_i)
        else begin
            fail_cnt++;
            $error("result valid or dispatch blocked one cycle after reset");
        end

endmodule

//--- tb/tb_alu_iq.sv
module tb_alu_iq
    import iq_pkg::*;
;

    localparam int IQ_SIZE   = 4;
    localparam int CDB_COUNT = 2;
    localparam int N_DISP    = 46;
    localparam int WATCHDOG  = 40 * N_DISP + 200;

    logic                 clk;
    logic                 reset_i;
    logic                 flush_i;
    logic                 disp_valid_i;
    dispatch_t            disp_i;
    logic                 disp_ready_o;
    cdb_t [CDB_COUNT-1:0] cdb_i;
    cdb_t                 res_o;
    logic                 res_valid_o;
    logic                 res_ready_i;

    integer  seed = 32'h93ff_c209;
    int      errors = 0;
    int      results = 0;
    int      outstanding = 0;
    int      bp_mode = 0;
    word_t   a;
    word_t   b;
    word_t   v1;
    word_t   v2;
    word_t   v3;

    // scoreboard by destination tag
    word_t   exp_val [16];
    bit      pend [16];
    bit      seen [16];
    bit      wait1 [16];
    bit      wait2 [16];
    rob_id_t tag1_of [16];
    rob_id_t tag2_of [16];

    alu_iq_top #(
        .IQ_SIZE   (IQ_SIZE),
        .AGE_W     (3),
        .CDB_COUNT (CDB_COUNT)
    ) dut (
        .clk          (clk),
        .reset_i      (reset_i),
        .flush_i      (flush_i),
        .disp_valid_i (disp_valid_i),
        .disp_i       (disp_i),
        .disp_ready_o (disp_ready_o),
        .cdb_i        (cdb_i),
        .res_o        (res_o),
        .res_valid_o  (res_valid_o),
        .res_ready_i  (res_ready_i)
    );

    bind alu_iq_top alu_iq_props #(.IQ_SIZE(IQ_SIZE)) u_props (
        .clk          (clk),
        .reset_i      (reset_i),
        .flush_i      (flush_i),
        .disp_ready_i (disp_ready_o),
        .alloc_i      (alloc),
        .busy_i       (ent_busy),
        .res_i        (res_o),
        .res_valid_i  (res_valid_o),
        .res_ready_i  (res_ready_i)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG) @(posedge clk);
        $display("watchdog expired after %0d cycles, results still missing", WATCHDOG);
        $display("TB FAILED");
        $finish;
    end

    // ----------------------------------------------------------------------
    // reference ALU and stimulus helpers
    function automatic word_t expect_alu(alu_op_e op, word_t x, word_t y);
        case (op)
            ADD: return x + y;
            SUB: return x + ~y + 32'd1;
            AND: return x & y;
            OR: return x | y;
            XOR: return x ^ y;
            SLL: return x << y[4:0];
            SRL: return x >> y[4:0];
            SLT: return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            default: return 32'd0;
        endcase
    endfunction

    task automatic send_op(input alu_op_e op, input logic use_imm,
                           input logic a_rdy, input rob_id_t a_tag, input word_t a_val,
                           input logic b_rdy, input rob_id_t b_tag, input word_t b_val,
                           input rob_id_t dst);
        dispatch_t d;
        d = '0;
        d.di.op         = op;
        d.di.use_imm    = use_imm;
        d.di.dst_id     = dst;
        d.src1.valid    = a_rdy;
        d.src1.tag      = a_tag;
        d.src1.value    = a_rdy ? a_val : 32'd0;
        d.src2_valid    = b_rdy;
        if (use_imm) begin
            d.src2.imm = b_val;
        end else begin
            d.src2.rs.tag = b_tag;
            d.src2_value  = b_rdy ? b_val : 32'd0;
        end
        exp_val[dst] = expect_alu(op, a_val, b_val);
        pend[dst]    = 1'b1;
        wait1[dst]   = !a_rdy;
        tag1_of[dst] = a_tag;
        wait2[dst]   = !use_imm && !b_rdy;
        tag2_of[dst] = b_tag;
        outstanding++;
        disp_i       = d;
        disp_valid_i = 1'b1;
        while (!disp_ready_o) @(negedge clk);
        @(negedge clk);
        disp_valid_i = 1'b0;
    endtask

    // one-cycle broadcast on a random CDB port
    task automatic broadcast(input rob_id_t tag, input word_t value);
        int port;
        port = $unsigned($random(seed)) % CDB_COUNT;
        cdb_i[port].valid  = 1'b1;
        cdb_i[port].rob_id = tag;
        cdb_i[port].data   = value;
        seen[tag] = 1'b1;
        @(negedge clk);
        cdb_i = '0;
    endtask

    // wait for all results, then forget the dependency marks
    task automatic drain();
        while (outstanding != 0) @(negedge clk);
        for (int k = 0; k < 16; k++) begin
            seen[k]  = 1'b0;
            wait1[k] = 1'b0;
            wait2[k] = 1'b0;
        end
    endtask

    always @(negedge clk) begin
        case (bp_mode)
            1: res_ready_i = 1'($random(seed));
            2: res_ready_i = 1'b0;
            default: res_ready_i = 1'b1;
        endcase
    end

    // ----------------------------------------------------------------------
    // result checks on every transfer
    always @(posedge clk) begin : result_monitor
        rob_id_t t;
        if (!reset_i && !flush_i && res_valid_o && res_ready_i) begin
            t = res_o.rob_id;
            results++;
            assert (res_o.valid) else begin
                errors++;
                $display("CHECK FAILED res_o.valid tag %h: got %h expected %h",
                         t, res_o.valid, 1'b1);
            end
            assert (pend[t]) else begin
                errors++;
                $display("result for tag %0d was not pending (duplicate or flushed)", t);
            end
            assert (res_o.data == exp_val[t]) else begin
                errors++;
                $display("CHECK FAILED res_o.data tag %h: got %h expected %h",
                         t, res_o.data, exp_val[t]);
            end
            assert ((!wait1[t] || seen[tag1_of[t]]) && (!wait2[t] || seen[tag2_of[t]]))
            else begin
                errors++;
                $display("result for tag %0d returned before its source was broadcast", t);
            end
            if (pend[t]) begin
                pend[t] = 1'b0;
                outstanding--;
            end
            seen[t] = 1'b1;
        end
    end

    initial begin
        reset_i      = 1'b1;
        flush_i      = 1'b0;
        disp_valid_i = 1'b0;
        disp_i       = '0;
        cdb_i        = '0;
        res_ready_i  = 1'b1;
        repeat (5) @(negedge clk);
        reset_i = 1'b0;
        @(negedge clk);

        // every opcode, register form then immediate form
        for (int form = 0; form < 2; form++) begin
            for (int k = 0; k < 8; k++) begin
                a = $random(seed);
                b = $random(seed);
                send_op(alu_op_e'(3'(k)), form == 1, 1'b1, 4'd0, a, 1'b1, 4'd0, b,
                        rob_id_t'(k));
            end
            drain();
        end

        // dependents on external CDB tags and on local results
        a  = $random(seed);
        b  = $random(seed);
        v1 = $random(seed);
        v2 = $random(seed);
        v3 = $random(seed);
        send_op(ADD, 1'b1, 1'b0, 4'd12, v1, 1'b1, 4'd0, b, 4'd0);
        send_op(XOR, 1'b0, 1'b1, 4'd0, a, 1'b0, 4'd13, v2, 4'd1);
        send_op(SUB, 1'b0, 1'b1, 4'd0, a, 1'b1, 4'd0, b, 4'd2);
        send_op(SLL, 1'b1, 1'b0, 4'd2, exp_val[2], 1'b1, 4'd0, b, 4'd3);
        send_op(SLT, 1'b0, 1'b0, 4'd3, exp_val[3], 1'b0, 4'd14, v3, 4'd4);
        repeat (6) @(negedge clk);
        broadcast(4'd12, v1);
        broadcast(4'd13, v2);
        broadcast(4'd14, v3);
        drain();

        // fill the queue with waiting entries
        v1 = $random(seed);
        for (int k = 0; k < IQ_SIZE; k++) begin
            b = $random(seed);
            send_op(alu_op_e'(3'(k + 2)), 1'b1, 1'b0, 4'd15, v1, 1'b1, 4'd0, b,
                    rob_id_t'(k));
        end
        assert (disp_ready_o == 1'b0) else begin
            errors++;
            $display("CHECK FAILED disp_ready_o: got %h expected %h", disp_ready_o, 1'b0);
        end
        disp_i           = '0;
        disp_i.di.dst_id = 4'd11;
        disp_valid_i     = 1'b1;
        repeat (3) @(negedge clk);
        disp_valid_i = 1'b0;
        broadcast(4'd15, v1);
        while (!disp_ready_o) @(negedge clk);
        send_op(OR, 1'b0, 1'b1, 4'd0, a, 1'b1, 4'd0, b, 4'd4);
        drain();

        // random back-pressure on the result port
        bp_mode = 1;
        for (int k = 0; k < 12; k++) begin
            a = $random(seed);
            b = $random(seed);
            send_op(alu_op_e'(3'($random(seed))), 1'($random(seed)), 1'b1, 4'd0, a,
                    1'b1, 4'd0, b, rob_id_t'(k));
        end
        drain();

        // flush with a held result and a full queue
        bp_mode = 2;
        repeat (2) @(negedge clk);
        for (int k = 0; k < 4; k++) begin
            send_op(ADD, 1'b0, 1'b1, 4'd0, a, 1'b1, 4'd0, b, rob_id_t'(k));
        end
        send_op(AND, 1'b0, 1'b0, 4'd14, a, 1'b1, 4'd0, b, 4'd4);
        repeat (4) @(negedge clk);
        flush_i = 1'b1;
        for (int k = 0; k < 16; k++) begin
            pend[k] = 1'b0;
        end
        outstanding = 0;
        @(negedge clk);
        flush_i = 1'b0;
        bp_mode = 0;
        for (int k = 5; k < 8; k++) begin
            b = $random(seed);
            send_op(SRL, 1'b1, 1'b1, 4'd0, a, 1'b1, 4'd0, b, rob_id_t'(k));
        end
        drain();
        repeat (4) @(negedge clk);

        $display("checks failed: %0d, assertion failures: %0d, results: %0d",
                 errors, dut.u_props.fail_cnt, results);
        if (errors == 0 && dut.u_props.fail_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
